//--- uart.f
+incdir+verif
design/uart_pkg.sv
design/uart_byte_fifo.sv
design/uart_tx_serializer.sv
design/uart_rx_sampler.sv
design/uart_bus_regs.sv
design/uart_top.sv
verif/uart_tb.sv

//--- verif/uart_tb_checks.svh
/*
 * Testbench helpers, included inside the uart_tb module body.
 * Bus tasks run one transfer at a time and return on the edge that
 * carried the ack. Every wait gives up after a fixed cycle or read count.
 */
`ifndef UART_TB_CHECKS_SVH
`define UART_TB_CHECKS_SVH

    // ==================================================================
    // Random numbers and compares
    // ==================================================================
    // 32-bit xorshift, state kept in rng_state
    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp)
            fail_now($sformatf("Fail at %0t ns: %s expected 0x%02h actual 0x%02h",
                               $time, name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [BUS_DW-1:0] exp,
                              input logic [BUS_DW-1:0] act);
        if (act !== exp)
            fail_now($sformatf("Fail at %0t ns: %s expected 0x%08h actual 0x%08h",
                               $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_now($sformatf("Fail at %0t ns: %s expected %0b actual %0b",
                               $time, name, exp, act));
    endtask

    // ==================================================================
    // Bus master
    // ==================================================================
    // Write ack comes in the same cycle as the strobe
    task automatic bus_write(input logic [15:0] adr, input logic [BUS_DW-1:0] dat);
        int n;
        @(posedge i_clk);
        bus_req.stb <= 1'b1;
        bus_req.we  <= 1'b1;
        bus_req.adr <= adr;
        bus_req.dat <= dat;
        n = 0;
        @(posedge i_clk);
        while (!bus_rsp.ack)
        begin
            n++;
            if (n > BUS_TIMEOUT)
                fail_now("Bus write was never acknowledged");
            @(posedge i_clk);
        end
        bus_req.stb <= 1'b0;
        bus_req.we  <= 1'b0;
    endtask

    // Read data is valid with the ack, one cycle after the request
    task automatic bus_read(input logic [15:0] adr, output logic [BUS_DW-1:0] dat);
        int n;
        @(posedge i_clk);
        bus_req.stb <= 1'b1;
        bus_req.we  <= 1'b0;
        bus_req.adr <= adr;
        n = 0;
        @(posedge i_clk);
        while (!bus_rsp.ack)
        begin
            n++;
            if (n > BUS_TIMEOUT)
                fail_now("Bus read was never acknowledged");
            @(posedge i_clk);
        end
        dat = bus_rsp.dat;
        bus_req.stb <= 1'b0;
    endtask

    // ==================================================================
    // Guarded waits
    // ==================================================================
    // Poll FR until one flag reaches the wanted level
    task automatic wait_fr_bit(input int pos, input logic level);
        logic [BUS_DW-1:0] fr;
        int n;
        n = 0;
        bus_read(REG_FR, fr);
        while (fr[pos] !== level)
        begin
            n++;
            if (n > FLAG_TIMEOUT)
                fail_now($sformatf("FR bit %0d never reached %0b", pos, level));
            bus_read(REG_FR, fr);
        end
    endtask

    task automatic wait_int_level(input logic level);
        int n;
        n = 0;
        @(posedge i_clk);
        while (uart_int !== level)
        begin
            n++;
            if (n > CYCLE_TIMEOUT)
                fail_now($sformatf("o_uart_int never reached %0b", level));
            @(posedge i_clk);
        end
    endtask

    // Serial monitor count of finished frames
    task automatic wait_frames(input int target);
        int n;
        n = 0;
        @(posedge i_clk);
        while (tx_seen < target)
        begin
            n++;
            if (n > CYCLE_TIMEOUT)
                fail_now($sformatf("Only %0d of %0d frames seen on o_uart_txd",
                                   tx_seen, target));
            @(posedge i_clk);
        end
    endtask

`endif

//--- verif/uart_tb.sv
`timescale 1ns/1ns
/*
 * Self-checking testbench for uart_top with serial driver and monitor.
 * Stimulus is random from a fixed seed, so every run is identical.
 * Stops at the first mismatch or timeout.
 */
module uart_tb;
    import uart_pkg::*;

    localparam int BUS_TIMEOUT   = 16;
    localparam int FLAG_TIMEOUT  = 5000;
    localparam int CYCLE_TIMEOUT = 50000;

    logic              i_clk;
    logic              i_rst_n;
    bus_req_t          bus_req;
    bus_rsp_t          bus_rsp;
    logic              uart_int;
    logic              cts_n;
    logic              txd;
    logic              rts_n;
    logic              rxd;
    logic [31:0]       rng_state;
    // Expected byte streams
    // The rx queue size also models the rx FIFO occupancy
    logic [DATA_W-1:0] tx_exp [$];
    logic [DATA_W-1:0] rx_exp [$];
    // Serial monitor state
    int                tx_seen;
    int                mon_cnt;
    int                mon_slot;
    logic              mon_prev;
    logic [DATA_W-1:0] mon_byte;

    uart_top dut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_bus_req    (bus_req),
        .o_bus_rsp    (bus_rsp),
        .o_uart_int   (uart_int),
        .i_uart_cts_n (cts_n),
        .o_uart_txd   (txd),
        .o_uart_rts_n (rts_n),
        .i_uart_rxd   (rxd)
    );

    always #4 i_clk = ~i_clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    `include "uart_tb_checks.svh"

    // ==================================================================
    // Serial models
    // ==================================================================
    // Count 1 is the first low sample
    // Mid start bit is BIT_CYCLES/2 later
    always @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            mon_cnt  = 0;
            mon_prev = 1'b1;
            tx_seen  = 0;
        end
        else
        begin
            if (mon_cnt == 0)
            begin
                if (mon_prev && !txd)
                    mon_cnt = 1;
            end
            else
            begin
                mon_cnt = mon_cnt + 1;
                if ((mon_cnt - 1 - BIT_CYCLES / 2) % BIT_CYCLES == 0)
                begin
                    mon_slot = (mon_cnt - 1 - BIT_CYCLES / 2) / BIT_CYCLES;
                    if (mon_slot == 0)
                        check_bit("o_uart_txd start bit", 1'b0, txd);
                    else if (mon_slot <= DATA_W)
                        mon_byte = {txd, mon_byte[DATA_W-1:1]};
                    else
                    begin
                        check_bit("o_uart_txd stop bit", 1'b1, txd);
                        if (tx_exp.size() == 0)
                            fail_now("Frame on o_uart_txd without a byte written to DR");
                        check_byte("o_uart_txd", tx_exp.pop_front(), mon_byte);
                        tx_seen++;
                        mon_cnt = 0;
                    end
                end
            end
            mon_prev = txd;
        end
    end

    task automatic drive_rx_bit(input logic level);
        @(posedge i_clk);
        rxd <= level;
        repeat (BIT_CYCLES - 1) @(posedge i_clk);
    endtask

    // One stop bit plus two idle bits per frame
    task automatic send_serial(input logic [DATA_W-1:0] b);
        int i;
        if (rx_exp.size() < FIFO_DEPTH)
            rx_exp.push_back(b);
        drive_rx_bit(1'b0);
        for (i = 0; i < DATA_W; i++)
            drive_rx_bit(b[i]);
        repeat (3) drive_rx_bit(1'b1);
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial
    begin
        logic [BUS_DW-1:0] rd;
        logic [DATA_W-1:0] b;
        logic [15:0]       adr;
        int                i;
        int                seen;
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        bus_req   = '0;
        cts_n     = 1'b0;
        rxd       = 1'b1;
        rng_state = 32'hdbb8;
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // Reset state and registers
        repeat (3) @(posedge i_clk);
        check_bit("o_uart_txd", 1'b1, txd);
        check_bit("o_uart_int", 1'b0, uart_int);
        check_bit("o_uart_rts_n", 1'b0, rts_n);
        wait_fr_bit(0, 1'b1);
        bus_read(REG_FR, rd);
        check_word("FR", 32'h0000_0097, rd);
        for (i = 0; i < 4; i++)
        begin
            rd = xorshift_next();
            bus_write(REG_CR, rd);
            bus_read(REG_CR, rd);
            check_word("CR", {24'h0, rng_state[7:0]}, rd);
        end
        bus_write(REG_CR, '0);
        bus_read(16'h0004, rd);
        check_word("unmapped read", READ_DEFAULT, rd);
        for (i = 0; i < 4; i++)
        begin
            adr = 16'(xorshift_next() >> 16);
            // Low bits 01 never hit a mapped offset
            bus_read({adr[15:2], 2'b01}, rd);
            check_word("unmapped read", READ_DEFAULT, rd);
        end

        // Transmit paced on the tx full flag
        for (i = 0; i < 20; i++)
        begin
            wait_fr_bit(5, 1'b0);
            b = DATA_W'(xorshift_next());
            tx_exp.push_back(b);
            bus_write(REG_DR, BUS_DW'(b));
        end
        wait_frames(20);
        wait_fr_bit(7, 1'b1);

        // Receive
        for (i = 0; i < 10; i++)
            send_serial(DATA_W'(xorshift_next()));
        for (i = 0; i < 10; i++)
        begin
            bus_read(REG_DR, rd);
            check_byte("DR", rx_exp.pop_front(), rd[DATA_W-1:0]);
        end
        bus_read(REG_FR, rd);
        check_bit("FR rx empty", 1'b1, rd[4]);

        // Flow control holds off the start while cts_n is high
        @(posedge i_clk);
        cts_n <= 1'b1;
        wait_fr_bit(0, 1'b0);
        seen = tx_seen;
        for (i = 0; i < 3; i++)
        begin
            b = DATA_W'(xorshift_next());
            tx_exp.push_back(b);
            bus_write(REG_DR, BUS_DW'(b));
        end
        repeat (4 * TX_WORD_CYCLES)
        begin
            @(posedge i_clk);
            check_bit("o_uart_txd while cts_n high", 1'b1, txd);
        end
        cts_n <= 1'b0;
        wait_frames(seen + 3);
        wait_fr_bit(7, 1'b1);

        // Receive back-pressure drops the last two frames
        for (i = 0; i < 18; i++)
            send_serial(DATA_W'(xorshift_next()));
        bus_read(REG_FR, rd);
        check_bit("FR rx full", 1'b1, rd[6]);
        check_bit("o_uart_rts_n", 1'b1, rts_n);
        for (i = 0; i < FIFO_DEPTH; i++)
        begin
            bus_read(REG_DR, rd);
            check_byte("DR", rx_exp.pop_front(), rd[DATA_W-1:0]);
        end
        bus_read(REG_FR, rd);
        check_bit("FR rx empty", 1'b1, rd[4]);

        // Receive interrupt at FIFO_HALF bytes
        bus_write(REG_CR, BUS_DW'(1) << CR_RXIE_BIT);
        for (i = 0; i < FIFO_HALF - 1; i++)
            send_serial(DATA_W'(xorshift_next()));
        check_bit("o_uart_int", 1'b0, uart_int);
        send_serial(DATA_W'(xorshift_next()));
        check_bit("o_uart_int", 1'b1, uart_int);
        bus_read(REG_DR, rd);
        check_byte("DR", rx_exp.pop_front(), rd[DATA_W-1:0]);
        wait_int_level(1'b0);
        for (i = 1; i < FIFO_HALF; i++)
        begin
            bus_read(REG_DR, rd);
            check_byte("DR", rx_exp.pop_front(), rd[DATA_W-1:0]);
        end

        // Transmit interrupt cleared for one cycle by an IIR write
        bus_write(REG_CR, BUS_DW'(1) << CR_TXIE_BIT);
        wait_int_level(1'b1);
        bus_read(REG_IIR, rd);
        check_word("IIR", 32'h0000_0004, rd);
        bus_write(REG_IIR, '0);
        @(posedge i_clk);
        check_bit("o_uart_int after clear", 1'b0, uart_int);
        @(posedge i_clk);
        check_bit("o_uart_int after clear", 1'b1, uart_int);
        bus_write(REG_CR, '0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- design/uart_top.sv
`timescale 1ns/1ns
/*
 * Byte UART top with 16-entry transmit and receive FIFOs.
 * Fixed baud rate, 8 data bits, no parity, hardware flow control.
 */
module uart_top (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  uart_pkg::bus_req_t i_bus_req,
    output uart_pkg::bus_rsp_t o_bus_rsp,
    output logic               o_uart_int,
    input  logic               i_uart_cts_n,
    output logic               o_uart_txd,
    output logic               o_uart_rts_n,
    input  logic               i_uart_rxd
);
    import uart_pkg::*;

    logic              tx_push;
    logic [DATA_W-1:0] tx_wbyte;
    logic              tx_pop;
    logic [DATA_W-1:0] tx_head;
    fifo_stat_t        tx_stat;
    logic              rx_push;
    logic [DATA_W-1:0] rx_wbyte;
    logic              rx_pop;
    logic [DATA_W-1:0] rx_head;
    fifo_stat_t        rx_stat;
    logic              cts_sync;

    uart_bus_regs u_bus_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_bus_req  (i_bus_req),
        .o_bus_rsp  (o_bus_rsp),
        .o_tx_push  (tx_push),
        .o_tx_byte  (tx_wbyte),
        .i_tx_stat  (tx_stat),
        .o_rx_pop   (rx_pop),
        .i_rx_byte  (rx_head),
        .i_rx_stat  (rx_stat),
        .i_cts_sync (cts_sync),
        .o_uart_int (o_uart_int)
    );

    // Half flag means at most half full on the transmit side
    uart_byte_fifo #(.HALF_IS_UPPER(1'b0)) u_tx_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (tx_push),
        .i_wdata (tx_wbyte),
        .i_pop   (tx_pop),
        .o_rdata (tx_head),
        .o_stat  (tx_stat)
    );

    uart_byte_fifo #(.HALF_IS_UPPER(1'b1)) u_rx_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (rx_push),
        .i_wdata (rx_wbyte),
        .i_pop   (rx_pop),
        .o_rdata (rx_head),
        .o_stat  (rx_stat)
    );

    uart_tx_serializer u_tx (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_byte       (tx_head),
        .i_fifo_empty (tx_stat.empty),
        .o_pop        (tx_pop),
        .i_uart_cts_n (i_uart_cts_n),
        .o_cts_sync   (cts_sync),
        .o_uart_txd   (o_uart_txd)
    );

    uart_rx_sampler u_rx (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_uart_rxd   (i_uart_rxd),
        .i_fifo_full  (rx_stat.full),
        .o_push       (rx_push),
        .o_byte       (rx_wbyte),
        .o_uart_rts_n (o_uart_rts_n)
    );

endmodule

//--- design/uart_bus_regs.sv
`timescale 1ns/1ns
/*
 * Bus slave with the DR, CR, FR and IIR registers.
 * Writes ack in the same cycle, reads ack one cycle later.
 * A DR write to a full transmit FIFO is acked and the byte is dropped.
 */
module uart_bus_regs (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  uart_pkg::bus_req_t          i_bus_req,
    output uart_pkg::bus_rsp_t          o_bus_rsp,
    output logic                        o_tx_push,
    output logic [uart_pkg::DATA_W-1:0] o_tx_byte,
    input  uart_pkg::fifo_stat_t        i_tx_stat,
    output logic                        o_rx_pop,
    input  logic [uart_pkg::DATA_W-1:0] i_rx_byte,
    input  uart_pkg::fifo_stat_t        i_rx_stat,
    input  logic                        i_cts_sync,
    output logic                        o_uart_int
);
    import uart_pkg::*;

    logic              start_write;
    logic              start_read;
    logic              start_read_d1;
    logic [DATA_W-1:0] cr;
    logic [DATA_W-1:0] flags;
    logic              tx_int;
    logic              rx_int;
    logic [BUS_DW-1:0] rd_mux;
    logic [BUS_DW-1:0] rdata;

    // ==================================================================
    // Handshake
    // ==================================================================
    // Read ack due this cycle holds off a new write
    assign start_write   = i_bus_req.stb && i_bus_req.we && !start_read_d1;
    assign start_read    = i_bus_req.stb && !i_bus_req.we && !o_bus_rsp.ack;
    assign o_bus_rsp.ack = i_bus_req.stb && (start_write || start_read_d1);
    assign o_bus_rsp.dat = rdata;

    // FIFO side effects
    assign o_tx_push = start_write && i_bus_req.adr == REG_DR;
    assign o_tx_byte = i_bus_req.dat[DATA_W-1:0];
    assign o_rx_pop  = start_read && i_bus_req.adr == REG_DR;

    // ==================================================================
    // Control register and interrupts
    // ==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            start_read_d1 <= 1'b0;
            cr            <= '0;
            tx_int        <= 1'b0;
            rx_int        <= 1'b0;
        end
        else
        begin
            start_read_d1 <= start_read;
            if (start_write && i_bus_req.adr == REG_CR)
                cr <= i_bus_req.dat[DATA_W-1:0];
            // Clear wins for one cycle, then the level sets it again
            if (start_write && i_bus_req.adr == REG_IIR)
                tx_int <= 1'b0;
            else
                tx_int <= i_tx_stat.half && cr[CR_TXIE_BIT];
            rx_int <= i_rx_stat.half;
        end
    end

    assign o_uart_int = (tx_int && cr[CR_TXIE_BIT]) || (rx_int && cr[CR_RXIE_BIT]);

    // ==================================================================
    // Read path
    // ==================================================================
    // Tx empty, rx full, tx full, rx empty, busy, DCD, DSR, CTS
    assign flags = {i_tx_stat.empty, i_rx_stat.full, i_tx_stat.full, i_rx_stat.empty,
                    !i_tx_stat.empty, 1'b1, 1'b1, !i_cts_sync};

    always_comb
    begin
        case (i_bus_req.adr)
            REG_DR:  rd_mux = BUS_DW'(i_rx_byte);
            REG_CR:  rd_mux = BUS_DW'(cr);
            REG_FR:  rd_mux = BUS_DW'(flags);
            REG_IIR: rd_mux = BUS_DW'({tx_int, rx_int, 1'b0});
            default: rd_mux = READ_DEFAULT;
        endcase
    end

    // DR head captured in the same cycle as its pop
    always_ff @(posedge i_clk)
    begin
        if (start_read)
            rdata <= rd_mux;
    end

    // Read ack only while strobed and one cycle after a read request
    a_read_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_bus_rsp.ack && !i_bus_req.we |->
            i_bus_req.stb && $past(i_bus_req.stb && !i_bus_req.we));

endmodule

//--- design/uart_rx_sampler.sv
`timescale 1ns/1ns
/*
 * Receive side, 8 data bits LSB first, one stop bit, no parity.
 * The stop bit is not checked. While the FIFO is full the receiver stays
 * disarmed with rts_n high, and incoming frames are lost.
 */
module uart_rx_sampler (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_uart_rxd,
    input  logic                        i_fifo_full,
    output logic                        o_push,
    output logic [uart_pkg::DATA_W-1:0] o_byte,
    output logic                        o_uart_rts_n
);
    import uart_pkg::*;

    logic [4:0]                    rxd_d;
    logic                          rx_start;
    logic [$clog2(BIT_CYCLES)-1:0] bit_cnt;
    logic                          bit_tick;
    logic                          sample;
    rx_state_e                     rx_state;
    logic                          rxen;
    logic [DATA_W-1:0]             rx_byte;

    // ==================================================================
    // Input history and start detection
    // ==================================================================
    // Two highs then two lows, the middle sample is a don't care
    assign rx_start = rxd_d[4:3] == 2'b11 && rxd_d[1:0] == 2'b00;

    // Mid-bit point of the current slot
    assign bit_tick = bit_cnt == BIT_CYCLES - 1;
    assign sample   = bit_tick && (rx_state inside {[RX_DATA0:RX_DATA7]});

    // ==================================================================
    // Frame FSM and restartable bit counter
    // ==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rxd_d    <= 5'h1f;
            bit_cnt  <= '0;
            rx_state <= RX_IDLE;
            rxen     <= 1'b0;
        end
        else
        begin
            rxd_d   <= {rxd_d[3:0], i_uart_rxd};
            bit_cnt <= bit_cnt + 1'b1;
            case (rx_state)
                RX_IDLE:
                begin
                    // Arm only with room for the byte
                    rxen <= !i_fifo_full;
                    if (!i_fifo_full)
                        rx_state <= RX_START;
                end
                RX_START:
                    if (rx_start)
                    begin
                        rx_state <= RX_START_MID1;
                        bit_cnt  <= '0;
                    end
                // Part of the fixed delay to the start bit middle
                RX_START_MID1:
                    rx_state <= RX_START_MID;
                RX_START_MID:
                    if (bit_cnt == RX_HALF_CYCLES)
                    begin
                        rx_state <= RX_DATA0;
                        bit_cnt  <= '0;
                    end
                RX_DATA0, RX_DATA1, RX_DATA2, RX_DATA3,
                RX_DATA4, RX_DATA5, RX_DATA6, RX_DATA7:
                    if (bit_tick)
                    begin
                        rx_state <= rx_state_e'(rx_state + 4'd1);
                        bit_cnt  <= '0;
                    end
                // Half a bit into stop, byte goes out with the push
                RX_STOP:
                    if (bit_tick)
                        rx_state <= RX_IDLE;
                default:
                    rx_state <= RX_IDLE;
            endcase
        end
    end

    // Shift register, LSB arrives first
    always_ff @(posedge i_clk)
    begin
        if (rx_state == RX_IDLE)
            rx_byte <= '0;
        else if (sample)
            rx_byte <= {rxd_d[1], rx_byte[DATA_W-1:1]};
    end

    assign o_push       = rx_state == RX_STOP && bit_tick;
    assign o_byte       = rx_byte;
    assign o_uart_rts_n = ~rxen;

    // Arming rule keeps the FIFO from filling mid-frame
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_push |-> !i_fifo_full);

endmodule

//--- design/uart_tx_serializer.sv
`timescale 1ns/1ns
/*
 * Transmit side, 8 data bits LSB first, no parity.
 * A frame starts only on a free-running bit tick, so start latency varies
 * by up to one bit. The head byte must stay stable until STOP3 ends.
 */
module uart_tx_serializer (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic [uart_pkg::DATA_W-1:0] i_byte,
    input  logic                        i_fifo_empty,
    output logic                        o_pop,
    input  logic                        i_uart_cts_n,
    output logic                        o_cts_sync,
    output logic                        o_uart_txd
);
    import uart_pkg::*;

    logic [3:0]                    cts_d;
    logic                          cts_ok;
    logic [$clog2(BIT_CYCLES)-1:0] bit_cnt;
    logic                          bit_wrap;
    logic                          bit_tick;
    tx_state_e                     tx_state;
    tx_state_e                     tx_next;
    logic [2:0]                    bit_sel;
    logic                          txd_next;

    // ==================================================================
    // Clear-to-send synchronizer and bit timer
    // ==================================================================
    // Low for three synchronized samples before a frame may start
    assign cts_ok     = cts_d[3:1] == 3'b000;
    assign o_cts_sync = cts_d[3];

    // Period shortened in STOP2 to trim the frame length
    assign bit_wrap = (tx_state == TX_STOP2) ? (bit_cnt == TX_STOP2_CYCLES - 1)
                                             : (bit_cnt == BIT_CYCLES - 1);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cts_d    <= 4'hf;
            bit_cnt  <= '0;
            bit_tick <= 1'b0;
        end
        else
        begin
            cts_d    <= {cts_d[2:0], i_uart_cts_n};
            bit_cnt  <= bit_wrap ? '0 : bit_cnt + 1'b1;
            bit_tick <= bit_wrap;
        end
    end

    // ==================================================================
    // Frame FSM
    // ==================================================================
    always_comb
    begin
        tx_next = tx_state;
        case (tx_state)
            TX_IDLE:
                if (cts_ok && !i_fifo_empty)
                    tx_next = TX_START;
            TX_START, TX_DATA0, TX_DATA1, TX_DATA2, TX_DATA3, TX_DATA4,
            TX_DATA5, TX_DATA6, TX_DATA7, TX_STOP1, TX_STOP2:
                tx_next = tx_state_e'(tx_state + 4'd1);
            default:
                tx_next = TX_IDLE;
        endcase
    end

    // Line level for the slot being entered
    always_comb
    begin
        bit_sel = 3'(tx_next - TX_DATA0);
        if (tx_next == TX_START)
            txd_next = 1'b0;
        else if (tx_next inside {[TX_DATA0:TX_DATA7]})
            txd_next = i_byte[bit_sel];
        else
            txd_next = 1'b1;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            tx_state   <= TX_IDLE;
            o_uart_txd <= 1'b1;
        end
        else if (bit_tick)
        begin
            tx_state   <= tx_next;
            o_uart_txd <= txd_next;
        end
    end

    // Byte retired once the last stop slot ends
    assign o_pop = tx_state == TX_STOP3 && bit_tick && !i_fifo_empty;

    a_txd_idle_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        tx_state inside {TX_IDLE, TX_STOP1, TX_STOP2, TX_STOP3} |-> o_uart_txd);

endmodule

//--- design/uart_byte_fifo.sv
`timescale 1ns/1ns
/*
 * Flip-flop byte FIFO with a combinational head.
 * A push while full and a pop while empty are ignored.
 * HALF_IS_UPPER picks the sense of the half flag.
 */
module uart_byte_fifo #(
    parameter bit HALF_IS_UPPER = 1'b0
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_push,
    input  logic [uart_pkg::DATA_W-1:0] i_wdata,
    input  logic                        i_pop,
    output logic [uart_pkg::DATA_W-1:0] o_rdata,
    output uart_pkg::fifo_stat_t        o_stat
);
    import uart_pkg::*;

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW:0]  wr_ptr;
    logic [FIFO_AW:0]  rd_ptr;
    logic [FIFO_AW:0]  count;
    logic              empty;
    logic              full;
    logic              do_push;
    logic              do_pop;

    // Top pointer bit tracks wrap, so equal index with different wrap is full
    assign empty   = wr_ptr == rd_ptr;
    assign full    = wr_ptr == {~rd_ptr[FIFO_AW], rd_ptr[FIFO_AW-1:0]};
    assign do_push = i_push && !full;
    assign do_pop  = i_pop && !empty;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge i_clk)
    begin
        if (do_push)
            mem[wr_ptr[FIFO_AW-1:0]] <= i_wdata;
    end

    assign o_rdata      = mem[rd_ptr[FIFO_AW-1:0]];
    assign o_stat.empty = empty;
    assign o_stat.full  = full;
    assign o_stat.count = count;
    assign o_stat.half  = HALF_IS_UPPER ? (count >= FIFO_HALF) : (count <= FIFO_HALF);

    // Occupancy stays in range and agrees with the pointer distance
    a_count_ok: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        count <= FIFO_DEPTH && count == (FIFO_AW+1)'(wr_ptr - rd_ptr));

endmodule

//--- design/uart_pkg.sv
/*
 * Shared constants and types for the byte UART.
 * Baud rate is fixed at BIT_CYCLES clocks per bit and is not programmable.
 * Frames are 8 data bits with no parity.
 */
package uart_pkg;

    // ==================================================================
    // Data and FIFO sizing
    // ==================================================================
    localparam int DATA_W     = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;
    // Threshold for both FIFO interrupts
    localparam int FIFO_HALF  = 8;

    // ==================================================================
    // Serial bit timing
    // ==================================================================
    localparam int BIT_CYCLES      = 16;
    // 12 slots per frame, STOP2 takes what is left
    localparam int TX_WORD_CYCLES  = 184;
    localparam int TX_STOP2_CYCLES = TX_WORD_CYCLES - 11 * BIT_CYCLES;
    // Confirmed start edge to middle of start bit
    localparam int RX_HALF_CYCLES  = 6;

    // ==================================================================
    // Register map
    // ==================================================================
    localparam int                BUS_DW       = 32;
    localparam logic [BUS_DW-1:0] READ_DEFAULT = 32'h00c0ffee;
    localparam int                CR_RXIE_BIT  = 4;
    localparam int                CR_TXIE_BIT  = 5;

    // IIR doubles as the interrupt clear register on write
    typedef enum logic [15:0] {
        REG_DR  = 16'h0000,
        REG_CR  = 16'h0014,
        REG_FR  = 16'h0018,
        REG_IIR = 16'h001C
    } reg_addr_e;

    // Each state names the slot being driven on txd
    typedef enum logic [3:0] {
        TX_IDLE, TX_START,
        TX_DATA0, TX_DATA1, TX_DATA2, TX_DATA3,
        TX_DATA4, TX_DATA5, TX_DATA6, TX_DATA7,
        TX_STOP1, TX_STOP2, TX_STOP3
    } tx_state_e;

    typedef enum logic [3:0] {
        RX_IDLE, RX_START, RX_START_MID1, RX_START_MID,
        RX_DATA0, RX_DATA1, RX_DATA2, RX_DATA3,
        RX_DATA4, RX_DATA5, RX_DATA6, RX_DATA7,
        RX_STOP
    } rx_state_e;

    // Master to slave
    typedef struct packed {
        logic              stb;
        logic              we;
        logic [15:0]       adr;
        logic [BUS_DW-1:0] dat;
    } bus_req_t;

    typedef struct packed {
        logic              ack;
        logic [BUS_DW-1:0] dat;
    } bus_rsp_t;

    // Half means at most FIFO_HALF for tx, at least FIFO_HALF for rx
    typedef struct packed {
        logic             empty;
        logic             full;
        logic [FIFO_AW:0] count;
        logic             half;
    } fifo_stat_t;

endpackage
